//--- verilog/stream_pkg.sv
package stream_pkg;

  // operand and result width
  localparam int data_w = 16;

  typedef enum logic [1:0] {
    op_add   = 2'd0,
    op_sub   = 2'd1,
    op_cmp   = 2'd2, // three-way compare
    op_range = 2'd3  // b <= a <= c
  } alu_op_t;

  // request word, 50 bits
  typedef struct packed {
    alu_op_t           op;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] c; // upper bound, range check only
  } alu_req_t;

  // response word, 18 bits
  typedef struct packed {
    logic [data_w-1:0] result;
    logic              zero; // result all zeros
    logic              neg;  // msb of result
  } alu_rsp_t;

endpackage

//--- verilog/alu_stage.sv
`timescale 1ns/1ns

module alu_stage (
  input  stream_pkg::alu_req_t req,
  output stream_pkg::alu_rsp_t rsp
);
  import stream_pkg::*;

  logic              sub;
  logic [data_w-1:0] addend;
  logic [data_w-1:0] sum;
  logic              eq;
  logic              a_gt;
  logic              b_gt;
  logic              below_hi;
  logic              in_range;
  logic [data_w-1:0] result;

  // one adder for add and sub, two's complement via inverted b plus carry in
  assign sub    = (req.op == op_sub);
  assign addend = sub ? ~req.b : req.b;
  assign sum    = req.a + addend + data_w'(sub);

  // unsigned compare of a against b
  assign eq   = (req.a == req.b);
  assign a_gt = (req.a > req.b);
  assign b_gt = (req.b > req.a);

  // lower bound reuses the compare, a >= b is simply not b_gt
  assign below_hi = (req.a <= req.c);
  assign in_range = ~b_gt & below_hi;

  always_comb begin
    result = '0;
    case (req.op)
      op_add, op_sub: begin
        result = sum;
      end
      op_cmp: begin
        result[2:0] = {eq, a_gt, b_gt};
      end
      op_range: begin
        result[0] = in_range;
      end
    endcase
  end

  always_comb begin
    rsp.result = result;
    rsp.zero   = (result == '0);
    rsp.neg    = result[data_w-1];
  end

endmodule

//--- verilog/latency_pipe.sv
`timescale 1ns/1ns

module latency_pipe #(
  parameter int depth  = 6,
  parameter int fifo_k = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  stream_pkg::alu_rsp_t in_rsp,
  input  logic [fifo_k:0]      fifo_count,
  output logic                 in_stall,
  output logic                 pipe_valid,
  output stream_pkg::alu_rsp_t pipe_rsp
);
  import stream_pkg::*;

  localparam int cnt_w    = $clog2(depth + 1);
  localparam int wide_w   = (cnt_w > fifo_k + 1) ? cnt_w : fifo_k + 1;
  localparam int sum_w    = wide_w + 1;
  localparam int fifo_cap = 1 << fifo_k;

  logic [depth-1:0]     valid_sr;
  alu_rsp_t [depth-1:0] data_sr;
  logic [cnt_w-1:0]     in_flight;
  logic [sum_w-1:0]     reserved;
  logic                 accept;
  logic                 leave;

  assign accept = in_valid & ~in_stall;
  assign leave  = valid_sr[0]; // written into the fifo this edge

  assign pipe_valid = valid_sr[0];
  assign pipe_rsp   = data_sr[0];

  // every item in flight already owns a fifo slot, stall once they are all spoken for
  assign reserved = sum_w'(in_flight) + sum_w'(fifo_count);
  assign in_stall = (reserved >= sum_w'(fifo_cap));

  // new items enter at the top stage and walk down to stage zero
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {accept, valid_sr[depth-1:1]};
    end
  end

  // payload shifts every cycle, valid bits say which slots matter
  always_ff @(posedge clk) begin
    data_sr <= {in_rsp, data_sr[depth-1:1]};
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      case ({accept, leave})
        2'b10: begin
          in_flight <= in_flight + cnt_w'(1);
        end
        2'b01: begin
          in_flight <= in_flight - cnt_w'(1);
        end
        default: begin
          in_flight <= in_flight; // both or neither
        end
      endcase
    end
  end

endmodule

//--- verilog/result_fifo.sv
`timescale 1ns/1ns

module result_fifo #(
  parameter int fifo_k = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr,
  input  stream_pkg::alu_rsp_t wr_rsp,
  input  logic                 rd,
  output stream_pkg::alu_rsp_t head_rsp,
  output logic                 empty,
  output logic [fifo_k:0]      count
);
  import stream_pkg::*;

  localparam int entries = 1 << fifo_k;

  alu_rsp_t        mem [entries];
  logic [fifo_k:0] wr_ptr;
  logic [fifo_k:0] rd_ptr;
  logic            full;
  logic            do_wr;
  logic            do_rd;

  // pointers carry one extra wrap bit above the address
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr == {~rd_ptr[fifo_k], rd_ptr[fifo_k-1:0]});

  assign do_wr = wr & ~full;
  assign do_rd = rd & ~empty; // read on empty is dropped

  // first word fall through, head visible straight from the array
  assign head_rsp = mem[rd_ptr[fifo_k-1:0]];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[fifo_k-1:0]] <= wr_rsp;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({do_wr, do_rd})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

//--- verilog/credit_tx.sv
`timescale 1ns/1ns

module credit_tx #(
  parameter int credits = 4,
  parameter int fifo_k  = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 empty,
  input  stream_pkg::alu_rsp_t head_rsp,
  input  logic                 out_credit,
  output logic                 rd,
  output logic                 out_valid,
  output stream_pkg::alu_rsp_t out_rsp
);

  // counter at least as wide as the fifo occupancy
  localparam int credit_w = $clog2(credits + 1);
  localparam int cnt_w    = (credit_w > fifo_k + 1) ? credit_w : fifo_k + 1;

  logic [cnt_w-1:0] credit_cnt;
  logic             send;

  // a beat goes out only when there is data and the receiver has room
  assign send = ~empty & (credit_cnt != '0);

  assign rd        = send;
  assign out_valid = send;
  assign out_rsp   = head_rsp;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      credit_cnt <= cnt_w'(credits); // receiver buffer starts empty
    end else begin
      case ({send, out_credit})
        2'b10: begin
          credit_cnt <= credit_cnt - 1'b1;
        end
        2'b01: begin
          credit_cnt <= credit_cnt + 1'b1;
        end
        default: begin
          credit_cnt <= credit_cnt; // send and return cancel
        end
      endcase
    end
  end

endmodule

//--- verilog/stream_alu_top.sv
`timescale 1ns/1ns

module stream_alu_top #(
  parameter int depth   = 6,
  parameter int fifo_k  = 3,
  parameter int credits = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  stream_pkg::alu_req_t in_req,
  output logic                 in_stall,
  output logic                 out_valid,
  output stream_pkg::alu_rsp_t out_rsp,
  input  logic                 out_credit
);
  import stream_pkg::*;

  alu_rsp_t        alu_rsp;
  alu_rsp_t        pipe_rsp;
  alu_rsp_t        head_rsp;
  logic            pipe_valid;
  logic            fifo_rd;
  logic            fifo_empty;
  logic [fifo_k:0] fifo_count;

  alu_stage alu_stage_i (
    .req (in_req),
    .rsp (alu_rsp)
  );

  // fixed latency stage, stall reserves a fifo slot per accepted request
  latency_pipe #(
    .depth  (depth),
    .fifo_k (fifo_k)
  ) latency_pipe_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_rsp     (alu_rsp),
    .fifo_count (fifo_count),
    .in_stall   (in_stall),
    .pipe_valid (pipe_valid),
    .pipe_rsp   (pipe_rsp)
  );

  result_fifo #(
    .fifo_k (fifo_k)
  ) result_fifo_i (
    .clk      (clk),
    .rst      (rst),
    .wr       (pipe_valid),
    .wr_rsp   (pipe_rsp),
    .rd       (fifo_rd),
    .head_rsp (head_rsp),
    .empty    (fifo_empty),
    .count    (fifo_count)
  );

  credit_tx #(
    .credits (credits),
    .fifo_k  (fifo_k)
  ) credit_tx_i (
    .clk        (clk),
    .rst        (rst),
    .empty      (fifo_empty),
    .head_rsp   (head_rsp),
    .out_credit (out_credit),
    .rd         (fifo_rd),
    .out_valid  (out_valid),
    .out_rsp    (out_rsp)
  );

endmodule

//--- tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one table row, a request and the response it must produce
typedef struct packed {
  alu_req_t req;
  alu_rsp_t rsp;
} vec_t;

localparam int n_vec = 24;

// columns: '{op, a, b, c} then expected '{result, zero, neg}
vec_t vec_table [n_vec] = '{
  '{'{op_add,   16'h0001, 16'h0002, 16'h0000}, '{16'h0003, 1'b0, 1'b0}},
  '{'{op_add,   16'hffff, 16'h0001, 16'h0000}, '{16'h0000, 1'b1, 1'b0}}, // wraps to zero
  '{'{op_add,   16'h7fff, 16'h0001, 16'h0000}, '{16'h8000, 1'b0, 1'b1}},
  '{'{op_add,   16'h1234, 16'h4321, 16'h5a5a}, '{16'h5555, 1'b0, 1'b0}}, // c ignored
  '{'{op_sub,   16'h0005, 16'h0003, 16'h0000}, '{16'h0002, 1'b0, 1'b0}},
  '{'{op_sub,   16'h0003, 16'h0005, 16'h0000}, '{16'hfffe, 1'b0, 1'b1}},
  '{'{op_sub,   16'habcd, 16'habcd, 16'h0000}, '{16'h0000, 1'b1, 1'b0}},
  '{'{op_sub,   16'h0000, 16'h0001, 16'h0000}, '{16'hffff, 1'b0, 1'b1}},
  '{'{op_add,   16'h8000, 16'h8000, 16'h0000}, '{16'h0000, 1'b1, 1'b0}},
  // compare, bit 2 equal, bit 1 a greater, bit 0 b greater
  '{'{op_cmp,   16'h0010, 16'h0010, 16'h0000}, '{16'h0004, 1'b0, 1'b0}},
  '{'{op_cmp,   16'h0020, 16'h0010, 16'h0000}, '{16'h0002, 1'b0, 1'b0}},
  '{'{op_cmp,   16'h0010, 16'h0020, 16'h0000}, '{16'h0001, 1'b0, 1'b0}},
  '{'{op_cmp,   16'hffff, 16'h0000, 16'h0000}, '{16'h0002, 1'b0, 1'b0}},
  '{'{op_cmp,   16'h0000, 16'h8000, 16'h0000}, '{16'h0001, 1'b0, 1'b0}},
  // range, b <= a <= c
  '{'{op_range, 16'h0010, 16'h0005, 16'h0020}, '{16'h0001, 1'b0, 1'b0}},
  '{'{op_range, 16'h0005, 16'h0005, 16'h0020}, '{16'h0001, 1'b0, 1'b0}}, // lower bound
  '{'{op_range, 16'h0020, 16'h0005, 16'h0020}, '{16'h0001, 1'b0, 1'b0}}, // upper bound
  '{'{op_range, 16'h0004, 16'h0005, 16'h0020}, '{16'h0000, 1'b1, 1'b0}},
  '{'{op_range, 16'h0021, 16'h0005, 16'h0020}, '{16'h0000, 1'b1, 1'b0}},
  '{'{op_range, 16'h1000, 16'h2000, 16'h0100}, '{16'h0000, 1'b1, 1'b0}}, // empty range
  '{'{op_add,   16'h00ff, 16'h0f01, 16'h0000}, '{16'h1000, 1'b0, 1'b0}},
  '{'{op_sub,   16'h8000, 16'h0001, 16'h0000}, '{16'h7fff, 1'b0, 1'b0}},
  '{'{op_cmp,   16'h1234, 16'h1234, 16'hffff}, '{16'h0004, 1'b0, 1'b0}},
  '{'{op_range, 16'hffff, 16'h0000, 16'hffff}, '{16'h0001, 1'b0, 1'b0}}
};

`endif

//--- tests/tb_stream_alu.sv
`timescale 1ns/1ns

module tb_stream_alu;
  import stream_pkg::*;

  `include "tb_vectors.svh"

  localparam int depth         = 6;
  localparam int fifo_k        = 3;
  localparam int credits       = 4;
  localparam int hold_cycles   = 40; // credits withheld this long
  localparam int timeout_cycles = n_vec * (depth + 16) + 200;

  logic     clk;
  logic     rst;
  logic     in_valid;
  alu_req_t in_req;
  logic     in_stall;
  logic     out_valid;
  alu_rsp_t out_rsp;
  logic     out_credit;

  integer seed = 32'he768f7d2;
  int     exp_idx = 0;    // next expected table entry
  int     n_accepted = 0;
  int     rx_count = 0;   // beats held in the receiver buffer
  int     n_popped = 0;
  bit     holding = 1'b0; // receiver is withholding credits
  bit     saw_stall = 1'b0;
  bit     failed = 1'b0;

  stream_alu_top #(
    .depth   (depth),
    .fifo_k  (fifo_k),
    .credits (credits)
  ) stream_alu_top_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_req     (in_req),
    .in_stall   (in_stall),
    .out_valid  (out_valid),
    .out_rsp    (out_rsp),
    .out_credit (out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  // offer each entry until it is taken, stall holds the same request
  task automatic drive_requests();
    int idx;
    idx = 0;
    while (idx < n_vec) begin
      @(negedge clk);
      in_valid = 1'b1;
      in_req   = vec_table[idx].req;
      @(posedge clk);
      if (!in_stall) begin
        idx++;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    in_req   = '0;
  endtask

  initial begin
    rst      = 1'b1;
    in_valid = 1'b0;
    in_req   = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    assert (!out_valid && !in_stall) else begin
      $display("Error: after reset out_valid = %h, in_stall = %h, expected 0",
               out_valid, in_stall);
      abort_run();
    end
    drive_requests();
    wait (exp_idx == n_vec);
    repeat (depth + 8) @(posedge clk); // catch duplicated beats
    assert (saw_stall) else begin
      $display("in_stall never rose while credits were withheld");
      failed = 1'b1;
    end
    if (!failed) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  // ordered checker and receiver buffer fill, sampled on the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      if (out_valid) begin
        assert (exp_idx < n_vec) else begin
          $display("received a result beat after all %0d results arrived", n_vec);
          abort_run();
        end
        assert (exp_idx < n_accepted) else begin
          $display("out_valid came before its request was accepted");
          abort_run();
        end
        assert (out_rsp.result == vec_table[exp_idx].rsp.result) else begin
          $display("Error: out_rsp.result = %h, expected %h (entry %0d)",
                   out_rsp.result, vec_table[exp_idx].rsp.result, exp_idx);
          abort_run();
        end
        assert (out_rsp.zero == vec_table[exp_idx].rsp.zero) else begin
          $display("Error: out_rsp.zero = %h, expected %h (entry %0d)",
                   out_rsp.zero, vec_table[exp_idx].rsp.zero, exp_idx);
          abort_run();
        end
        assert (out_rsp.neg == vec_table[exp_idx].rsp.neg) else begin
          $display("Error: out_rsp.neg = %h, expected %h (entry %0d)",
                   out_rsp.neg, vec_table[exp_idx].rsp.neg, exp_idx);
          abort_run();
        end
        exp_idx++;
        rx_count++;
        assert (rx_count <= credits) else begin
          $display("receiver buffer overflow, %0d beats held with room for %0d",
                   rx_count, credits);
          abort_run();
        end
      end
      if (in_valid && !in_stall) begin
        n_accepted++;
      end
      if (holding && in_stall) begin
        saw_stall = 1'b1;
      end
    end
  end

  // receiver drains its buffer after random delays and returns credits
  initial begin
    int delay;
    out_credit = 1'b0;
    forever begin
      @(negedge clk);
      out_credit = 1'b0;
      if (rx_count > 0) begin
        delay = $unsigned($random(seed)) % 8;
        if (n_popped == 4 || n_popped == 14) begin
          holding = 1'b1;
          repeat (hold_cycles) @(negedge clk); // back-pressure stretch
          holding = 1'b0;
        end
        repeat (delay) @(negedge clk);
        out_credit = 1'b1;
        rx_count--;
        n_popped++;
      end
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout, only %0d of %0d results arrived within %0d cycles",
             exp_idx, n_vec, timeout_cycles);
    abort_run();
  end

endmodule

//--- compile.f
+incdir+tests
verilog/stream_pkg.sv
verilog/alu_stage.sv
verilog/latency_pipe.sv
verilog/result_fifo.sv
verilog/credit_tx.sv
verilog/stream_alu_top.sv
tests/tb_stream_alu.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_stream_alu -Mdir obj_dir \
  && ./obj_dir/Vtb_stream_alu | tee /dev/stderr | grep -qx "=== PASS ===" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
